// ==== src.f ====
rtl/cmd_ctl_pkg.sv
rtl/cmd_reg_file.sv
rtl/cmd_executor.sv
rtl/cmd_resp_tx.sv
rtl/cmd_ctl_top.sv
bench/cmd_ctl_asserts.sv
bench/cmd_ctl_tb.sv

// ==== Bender.yml ====
package:
  name: cmd_ctl

sources:
  - rtl/cmd_ctl_pkg.sv
  - rtl/cmd_reg_file.sv
  - rtl/cmd_executor.sv
  - rtl/cmd_resp_tx.sv
  - rtl/cmd_ctl_top.sv
  - target: test
    files:
      - bench/cmd_ctl_asserts.sv
      - bench/cmd_ctl_tb.sv

// ==== bench/cmd_ctl_tb.sv ====
// Testbench for the command controller with clock, reset, random commands, host model and checks
module cmd_ctl_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cmd_ctl_pkg::*;

	localparam int n_cmds = 150;
	localparam int cycle_limit = n_cmds * 300 + 16;

	logic              clk_in = 1'b0;
	logic              rst_in;
	logic              prg_wrena;
	logic [addr_w-1:0] prg_addr;
	logic [data_w-1:0] prg_wrdata;
	logic [data_w-1:0] prg_rddata;
	logic [data_w-1:0] rx_block_size;
	logic              soft_resetn;
	logic              enable_sfp1;
	logic              enable_sfp2;
	logic              set_lpbk;
	logic              unset_lpbk;
	logic              reset_nios;
	logic              irq_prg_wrena;
	logic [addr_w-1:0] irq_prg_addr;
	logic [data_w-1:0] irq_prg_wrdata;
	logic              tx_req;
	logic              tx_ack;
	logic [resp_w-1:0] tx_data;

	integer                   seed = 97558;
	logic [resp_w-1:0]        exp_resp[$];
	logic [addr_w+data_w-1:0] exp_irq[$];
	int                       n_received = 0;
	int                       resetn_low = 0;
	int                       nios_high = 0;
	logic                     model_sfp1;
	logic                     model_sfp2;
	logic                     model_set;
	logic                     model_unset;

	cmd_ctl_top dut_i (.*);

	always #5 clk_in = ~clk_in;

	// ------------------------------------------------------------------------
	// Checking helpers and reference model
	// ------------------------------------------------------------------------
	task automatic end_with_failure();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [resp_w-1:0] expected,
			input logic [resp_w-1:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
			end_with_failure();
		end
	endtask

	// Data low, error code in the middle, echoed type on top
	function automatic logic [resp_w-1:0] expected_response(input logic [data_w-1:0] code,
			input logic [data_w-1:0] block_size);
		logic [63:0]       data;
		logic [data_w-1:0] err;
		data = '0;
		err = resp_ok;
		if (code == cmd_get_rx_size || code == cmd_get_tx_size) begin
			data = 64'(ring_size);
		end else if (code == cmd_get_rx_block_size) begin
			data = 64'(block_size);
		end else if (code == cmd_none || code > cmd_init_netlogic) begin
			err = resp_unknown;
		end
		return {code, err, data};
	endfunction

	// ------------------------------------------------------------------------
	// Host register port
	// ------------------------------------------------------------------------
	task automatic host_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		@(posedge clk_in);
		#1;
		prg_wrena = 1'b1;
		prg_addr = addr;
		prg_wrdata = data;
		@(posedge clk_in);
		#1;
		prg_wrena = 1'b0;
	endtask

	task automatic host_read_check(input string name, input logic [addr_w-1:0] addr,
			input logic [data_w-1:0] expected);
		@(posedge clk_in);
		#1;
		prg_addr = addr;
		@(posedge clk_in);
		#1;
		check(name, expected, prg_rddata);
	endtask

	// Command is done once cmd_dw0 reads back zero
	task automatic wait_cmd_done();
		@(posedge clk_in);
		#1;
		prg_addr = reg_cmd_dw0;
		do begin
			@(posedge clk_in);
			#1;
		end while (prg_rddata != '0);
	endtask

	// Pulse lengths, irq strobes and loopback exclusion, sampled mid-cycle
	always @(negedge clk_in) begin
		if (!rst_in) begin
			if (!soft_resetn) begin
				resetn_low++;
			end
			if (reset_nios) begin
				nios_high++;
			end
			check("loopback exclusive", '0, set_lpbk & unset_lpbk);
			check("assertion failures", '0, dut_i.resp_tx_i.asserts_i.fail_count);
			if (irq_prg_wrena) begin
				if (exp_irq.size() == 0) begin
					$display("Unexpected interrupt register write to %0h", irq_prg_addr);
					end_with_failure();
				end else begin
					check("irq write", exp_irq.pop_front(), {irq_prg_addr, irq_prg_wrdata});
				end
			end
		end
	end

	// Host side of the tx link with random ack delay
	initial begin : host_tx
		int                delay;
		logic [resp_w-1:0] word;
		forever begin
			@(posedge clk_in);
			#1;
			if (tx_req) begin
				word = tx_data;
				delay = {$random(seed)} % 9;
				repeat (delay) begin
					@(posedge clk_in);
					#1;
				end
				tx_ack = 1'b1;
				do begin
					@(posedge clk_in);
					#1;
				end while (tx_req);
				tx_ack = 1'b0;
				if (exp_resp.size() == 0) begin
					$display("Response received with no command outstanding");
					end_with_failure();
				end else begin
					check("response word", exp_resp.pop_front(), word);
					n_received++;
				end
			end
		end
	end

	initial begin : watchdog
		#(cycle_limit * 10);
		$display("Timeout, the run did not finish within %0d cycles", cycle_limit);
		end_with_failure();
	end

	// ------------------------------------------------------------------------
	// Main stimulus
	// ------------------------------------------------------------------------
	initial begin
		logic [data_w-1:0] code;
		logic [data_w-1:0] p0;
		logic [data_w-1:0] p1;
		logic [data_w-1:0] p2;
		rst_in = 1'b1;
		prg_wrena = 1'b0;
		prg_addr = '0;
		prg_wrdata = '0;
		rx_block_size = '0;
		tx_ack = 1'b0;
		model_sfp1 = 1'b0;
		model_sfp2 = 1'b0;
		model_set = 1'b0;
		model_unset = 1'b0;
		repeat (16) @(posedge clk_in);
		#1;
		rst_in = 1'b0;
		check("reset levels", 8'b1000_0000, {soft_resetn, enable_sfp1, enable_sfp2,
			set_lpbk, unset_lpbk, reset_nios, irq_prg_wrena, tx_req});

		for (int i = 0; i < n_cmds; i++) begin
			code = {$random(seed)} % 18;
			// Codes 15 to 17 and wide values are unknown to the executor
			if (code == '0) begin
				code = $random(seed) | 32'h8000_0000;
			end
			p0 = $random(seed);
			p1 = $random(seed);
			p2 = $random(seed);
			rx_block_size = $random(seed);
			host_write(reg_cmd_dw1, p0);
			host_write(reg_cmd_dw2, p1);
			host_write(reg_cmd_dw3, p2);
			host_read_check("param0 readback", reg_cmd_dw1, p0);
			host_read_check("param1 readback", reg_cmd_dw2, p1);
			host_read_check("param2 readback", reg_cmd_dw3, p2);

			exp_resp.push_back(expected_response(code, rx_block_size));
			case (code)
				cmd_set_addr_irq: begin
					exp_irq.push_back({irq_cntl_dw1, p0});
					exp_irq.push_back({irq_cntl_dw2, p1});
				end
				cmd_config_irq: exp_irq.push_back({irq_cntl_dw0, p0});
				cmd_set_rx_block_size: exp_irq.push_back({irq_cntl_dw3, p0});
				default: begin
				end
			endcase
			resetn_low = 0;
			nios_high = 0;
			host_write(reg_cmd_dw0, code);
			wait_cmd_done();

			case (code)
				cmd_start_sfp1: model_sfp1 = 1'b1;
				cmd_stop_sfp1: model_sfp1 = 1'b0;
				cmd_start_sfp2: model_sfp2 = 1'b1;
				cmd_stop_sfp2: model_sfp2 = 1'b0;
				cmd_lpbk_on: {model_set, model_unset} = 2'b10;
				cmd_lpbk_off: {model_set, model_unset} = 2'b01;
				default: begin
				end
			endcase
			check("port enables", {model_sfp1, model_sfp2}, {enable_sfp1, enable_sfp2});
			check("loopback levels", {model_set, model_unset}, {set_lpbk, unset_lpbk});
			check("irq writes missing", '0, exp_irq.size());
			check("soft reset cycles", (code == cmd_reset) ? reset_cycles : '0, resetn_low);
			check("nios reset cycles", (code == cmd_init_netlogic) ? nios_pulse_cycles : '0,
				nios_high);
		end

		// Last response may still wait for the host
		while (n_received < n_cmds) begin
			@(posedge clk_in);
		end
		// Room for a repeated response to show up on the tx link
		repeat (20) @(posedge clk_in);
		#1;
		check("spare response", 1'b0, tx_req);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== bench/cmd_ctl_asserts.sv ====
// Concurrent assertions on the response sender handshakes, with bind to cmd_resp_tx
module cmd_ctl_asserts (
	input logic                           clk_in,
	input logic                           rst_in,
	input logic                           resp_req,
	input logic                           resp_ack,
	input logic                           tx_req,
	input logic                           tx_ack,
	input logic [cmd_ctl_pkg::resp_w-1:0] tx_data
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertion count
	int fail_count = 0;

	// Request held until the host answers
	tx_req_hold: assert property (@(posedge clk_in) disable iff (rst_in)
		tx_req && !tx_ack |=> tx_req)
	else begin
		fail_count++;
		$error("tx_req dropped before tx_ack");
	end

	tx_data_stable: assert property (@(posedge clk_in) disable iff (rst_in)
		tx_req |=> !tx_req || $stable(tx_data))
	else begin
		fail_count++;
		$error("tx_data changed while tx_req was high");
	end

	// No ack without a request on the executor link
	resp_ack_rise: assert property (@(posedge clk_in) disable iff (rst_in)
		!resp_req && !resp_ack |=> !resp_ack)
	else begin
		fail_count++;
		$error("resp_ack rose while resp_req was low");
	end

endmodule

bind cmd_resp_tx cmd_ctl_asserts asserts_i (
	.clk_in   (clk_in),
	.rst_in   (rst_in),
	.resp_req (resp_req),
	.resp_ack (resp_ack),
	.tx_req   (tx_req),
	.tx_ack   (tx_ack),
	.tx_data  (tx_data)
);

// ==== rtl/cmd_ctl_top.sv ====
// Top level of the host command controller, register file to executor to response sender
module cmd_ctl_top (
	input  logic                           clk_in,
	input  logic                           rst_in,

	// Host register port
	input  logic                           prg_wrena,
	input  logic [cmd_ctl_pkg::addr_w-1:0] prg_addr,
	input  logic [cmd_ctl_pkg::data_w-1:0] prg_wrdata,
	output logic [cmd_ctl_pkg::data_w-1:0] prg_rddata,

	input  logic [cmd_ctl_pkg::data_w-1:0] rx_block_size,

	// Card control
	output logic                           soft_resetn,
	output logic                           enable_sfp1,
	output logic                           enable_sfp2,
	output logic                           set_lpbk,
	output logic                           unset_lpbk,
	output logic                           reset_nios,

	// Interrupt register file
	output logic                           irq_prg_wrena,
	output logic [cmd_ctl_pkg::addr_w-1:0] irq_prg_addr,
	output logic [cmd_ctl_pkg::data_w-1:0] irq_prg_wrdata,

	// Response to the host
	output logic                           tx_req,
	input  logic                           tx_ack,
	output logic [cmd_ctl_pkg::resp_w-1:0] tx_data
);
	import cmd_ctl_pkg::*;

	logic              cmd_pending;
	logic              cmd_clear;
	cmd_t              cmd_type;
	logic [data_w-1:0] param0;
	logic [data_w-1:0] param1;
	logic [data_w-1:0] param2;
	logic              resp_req;
	logic              resp_ack;
	logic [resp_w-1:0] resp_word;

	// ------------------------------------------------------------------------
	// Stage 1, command registers
	// ------------------------------------------------------------------------
	cmd_reg_file reg_file_i (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.prg_wrena   (prg_wrena),
		.prg_addr    (prg_addr),
		.prg_wrdata  (prg_wrdata),
		.prg_rddata  (prg_rddata),
		.cmd_clear   (cmd_clear),
		.cmd_pending (cmd_pending),
		.cmd_type    (cmd_type),
		.param0      (param0),
		.param1      (param1),
		.param2      (param2)
	);

	// ------------------------------------------------------------------------
	// Stage 2, executor
	// ------------------------------------------------------------------------
	cmd_executor executor_i (
		.clk_in         (clk_in),
		.rst_in         (rst_in),
		.cmd_pending    (cmd_pending),
		.cmd_type       (cmd_type),
		.param0         (param0),
		.param1         (param1),
		.param2         (param2),
		.cmd_clear      (cmd_clear),
		.rx_block_size  (rx_block_size),
		.soft_resetn    (soft_resetn),
		.enable_sfp1    (enable_sfp1),
		.enable_sfp2    (enable_sfp2),
		.set_lpbk       (set_lpbk),
		.unset_lpbk     (unset_lpbk),
		.reset_nios     (reset_nios),
		.irq_prg_wrena  (irq_prg_wrena),
		.irq_prg_addr   (irq_prg_addr),
		.irq_prg_wrdata (irq_prg_wrdata),
		.resp_req       (resp_req),
		.resp_ack       (resp_ack),
		.resp_word      (resp_word)
	);

	// ------------------------------------------------------------------------
	// Stage 3, response sender
	// ------------------------------------------------------------------------
	cmd_resp_tx resp_tx_i (
		.clk_in    (clk_in),
		.rst_in    (rst_in),
		.resp_req  (resp_req),
		.resp_ack  (resp_ack),
		.resp_word (resp_word),
		.tx_req    (tx_req),
		.tx_ack    (tx_ack),
		.tx_data   (tx_data)
	);

endmodule

// ==== rtl/cmd_resp_tx.sv ====
// One-entry response buffer between the executor link and the host tx link
module cmd_resp_tx (
	input  logic                           clk_in,
	input  logic                           rst_in,

	// Executor link, slave side
	input  logic                           resp_req,
	output logic                           resp_ack,
	input  logic [cmd_ctl_pkg::resp_w-1:0] resp_word,

	// Host link, master side
	output logic                           tx_req,
	input  logic                           tx_ack,
	output logic [cmd_ctl_pkg::resp_w-1:0] tx_data
);
	import cmd_ctl_pkg::*;

	logic              full;
	logic              tx_wait;
	logic              take;
	logic [resp_w-1:0] buf_q;

	// New request only when idle on this link and the buffer is free
	assign take = resp_req && !resp_ack && !full;

	// ------------------------------------------------------------------------
	// Handshake control
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			full <= 1'b0;
			resp_ack <= 1'b0;
			tx_req <= 1'b0;
			tx_wait <= 1'b0;
		end else begin
			// Executor side
			if (resp_ack) begin
				if (!resp_req) begin
					resp_ack <= 1'b0;
				end
			end else if (take) begin
				resp_ack <= 1'b1;
				full <= 1'b1;
			end

			// Host side
			if (tx_req) begin
				if (tx_ack) begin
					tx_req <= 1'b0;
					tx_wait <= 1'b1;
				end
			end else if (tx_wait) begin
				// Entry is freed once the host drops its ack
				if (!tx_ack) begin
					tx_wait <= 1'b0;
					full <= 1'b0;
				end
			end else if (full) begin
				tx_req <= 1'b1;
			end
		end
	end

	// Response storage
	always_ff @(posedge clk_in) begin
		if (take) begin
			buf_q <= resp_word;
		end
	end

	assign tx_data = buf_q;

endmodule

// ==== rtl/cmd_executor.sv ====
// Command FSM, execute cycle counter, card control outputs, irq register writes, response build
module cmd_executor (
	input  logic                           clk_in,
	input  logic                           rst_in,

	// From the command register file
	input  logic                           cmd_pending,
	input  cmd_ctl_pkg::cmd_t              cmd_type,
	input  logic [cmd_ctl_pkg::data_w-1:0] param0,
	input  logic [cmd_ctl_pkg::data_w-1:0] param1,
	input  logic [cmd_ctl_pkg::data_w-1:0] param2,
	output logic                           cmd_clear,

	input  logic [cmd_ctl_pkg::data_w-1:0] rx_block_size,

	// Card control
	output logic                           soft_resetn,
	output logic                           enable_sfp1,
	output logic                           enable_sfp2,
	output logic                           set_lpbk,
	output logic                           unset_lpbk,
	output logic                           reset_nios,

	// Interrupt register file writes
	output logic                           irq_prg_wrena,
	output logic [cmd_ctl_pkg::addr_w-1:0] irq_prg_addr,
	output logic [cmd_ctl_pkg::data_w-1:0] irq_prg_wrdata,

	// Response to the sender
	output logic                           resp_req,
	input  logic                           resp_ack,
	output logic [cmd_ctl_pkg::resp_w-1:0] resp_word
);
	import cmd_ctl_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_execute,
		st_respond,
		st_release,
		st_writeback
	} state_t;

	state_t              state;
	logic [cnt_w-1:0]    cyc_cnt;
	logic [cnt_w-1:0]    exec_len;
	logic                exec_last;
	logic                cmd_start;
	logic                irq_wr;
	logic [addr_w-1:0]   irq_addr;
	logic [data_w-1:0]   irq_data;
	logic [resp_w/2-1:0] resp_data;
	logic [data_w-1:0]   resp_code;

	// Execute length per command
	always_comb begin
		case (cmd_type)
			cmd_reset:                 exec_len = reset_cycles;
			cmd_set_addr_irq:          exec_len = cnt_w'(2);
			cmd_lpbk_on, cmd_lpbk_off: exec_len = lpbk_cycles;
			cmd_init_netlogic:         exec_len = netlogic_cycles;
			default:                   exec_len = cnt_w'(1);
		endcase
	end

	assign cmd_start = state == st_idle && cmd_pending;
	assign exec_last = state == st_execute && cyc_cnt == exec_len - 1'b1;

	// ------------------------------------------------------------------------
	// State machine and cycle counter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state <= st_idle;
			cyc_cnt <= '0;
		end else begin
			cyc_cnt <= (state == st_execute) ? cyc_cnt + 1'b1 : '0;
			case (state)
				st_idle:      state <= cmd_pending ? st_execute : st_idle;
				st_execute:   state <= exec_last ? st_respond : st_execute;
				st_respond:   state <= resp_ack ? st_release : st_respond;
				st_release:   state <= resp_ack ? st_release : st_writeback;
				st_writeback: state <= st_idle;
				default:      state <= st_idle;
			endcase
		end
	end

	assign resp_req = state == st_respond;
	assign cmd_clear = state == st_writeback;

	// ------------------------------------------------------------------------
	// Card control levels, all changed on entry to execute
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			soft_resetn <= 1'b1;
			enable_sfp1 <= 1'b0;
			enable_sfp2 <= 1'b0;
			set_lpbk <= 1'b0;
			unset_lpbk <= 1'b0;
			reset_nios <= 1'b0;
		end else if (cmd_start) begin
			case (cmd_type)
				cmd_reset:         soft_resetn <= 1'b0;
				cmd_start_sfp1:    enable_sfp1 <= 1'b1;
				cmd_stop_sfp1:     enable_sfp1 <= 1'b0;
				cmd_start_sfp2:    enable_sfp2 <= 1'b1;
				cmd_stop_sfp2:     enable_sfp2 <= 1'b0;
				cmd_init_netlogic: reset_nios <= 1'b1;
				cmd_lpbk_on: begin
					set_lpbk <= 1'b1;
					unset_lpbk <= 1'b0;
				end
				cmd_lpbk_off: begin
					set_lpbk <= 1'b0;
					unset_lpbk <= 1'b1;
				end
				default: begin
				end
			endcase
		end else if (state == st_execute) begin
			// Soft reset spans the whole execute phase
			if (exec_last) begin
				soft_resetn <= 1'b1;
			end
			if (cyc_cnt == nios_pulse_cycles - 1'b1) begin
				reset_nios <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Interrupt register writes, one execute cycle per write
	// ------------------------------------------------------------------------
	// param2 is carried for three-argument commands; none of the current set uses it
	always_comb begin
		irq_wr = 1'b0;
		irq_addr = irq_cntl_dw0;
		irq_data = param0;
		if (state == st_execute) begin
			case (cmd_type)
				cmd_set_addr_irq: begin
					irq_wr = 1'b1;
					if (cyc_cnt == '0) begin
						irq_addr = irq_cntl_dw1;
					end else begin
						irq_addr = irq_cntl_dw2;
						irq_data = param1;
					end
				end
				cmd_config_irq: begin
					irq_wr = 1'b1;
				end
				cmd_set_rx_block_size: begin
					irq_wr = 1'b1;
					irq_addr = irq_cntl_dw3;
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			irq_prg_wrena <= 1'b0;
		end else begin
			irq_prg_wrena <= irq_wr;
		end
	end

	always_ff @(posedge clk_in) begin
		if (irq_wr) begin
			irq_prg_addr <= irq_addr;
			irq_prg_wrdata <= irq_data;
		end
	end

	// ------------------------------------------------------------------------
	// Response word
	// ------------------------------------------------------------------------
	always_comb begin
		resp_data = '0;
		resp_code = resp_ok;
		case (cmd_type)
			cmd_get_rx_size, cmd_get_tx_size: begin
				resp_data = {{data_w{1'b0}}, ring_size};
			end
			cmd_get_rx_block_size: begin
				resp_data = {{data_w{1'b0}}, rx_block_size};
			end
			cmd_reset, cmd_start_sfp1, cmd_stop_sfp1, cmd_start_sfp2, cmd_stop_sfp2,
			cmd_set_addr_irq, cmd_config_irq, cmd_set_rx_block_size,
			cmd_lpbk_on, cmd_lpbk_off, cmd_init_netlogic: begin
			end
			default: begin
				resp_code = resp_unknown;
			end
		endcase
	end

	// Echoed type on top, error code, then data
	always_ff @(posedge clk_in) begin
		if (cmd_start) begin
			resp_word <= {cmd_type, resp_code, resp_data};
		end
	end

endmodule

// ==== rtl/cmd_reg_file.sv ====
// Host command and parameter registers with readback, pending flag and executor clear
module cmd_reg_file (
	input  logic                           clk_in,
	input  logic                           rst_in,

	// Host register port
	input  logic                           prg_wrena,
	input  logic [cmd_ctl_pkg::addr_w-1:0] prg_addr,
	input  logic [cmd_ctl_pkg::data_w-1:0] prg_wrdata,
	output logic [cmd_ctl_pkg::data_w-1:0] prg_rddata,

	// Executor side
	input  logic                           cmd_clear,
	output logic                           cmd_pending,
	output cmd_ctl_pkg::cmd_t              cmd_type,
	output logic [cmd_ctl_pkg::data_w-1:0] param0,
	output logic [cmd_ctl_pkg::data_w-1:0] param1,
	output logic [cmd_ctl_pkg::data_w-1:0] param2
);
	import cmd_ctl_pkg::*;

	logic [data_w-1:0] type_q;
	logic [data_w-1:0] param0_q;
	logic [data_w-1:0] param1_q;
	logic [data_w-1:0] param2_q;
	logic              host_wr;

	// Registers are frozen while a command is in flight
	assign host_wr = prg_wrena && !cmd_pending;

	// ------------------------------------------------------------------------
	// Command type register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			type_q <= '0;
		end else if (cmd_clear) begin
			// Clear from the executor wins over a host write
			type_q <= '0;
		end else if (host_wr && prg_addr == reg_cmd_dw0) begin
			type_q <= prg_wrdata;
		end
	end

	// ------------------------------------------------------------------------
	// Parameter registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_in) begin
		if (host_wr) begin
			case (prg_addr)
				reg_cmd_dw1: begin
					param0_q <= prg_wrdata;
				end
				reg_cmd_dw2: begin
					param1_q <= prg_wrdata;
				end
				reg_cmd_dw3: begin
					param2_q <= prg_wrdata;
				end
				default: begin
				end
			endcase
		end
	end

	// Readback of the addressed register
	always_comb begin
		case (prg_addr)
			reg_cmd_dw0: begin
				prg_rddata = type_q;
			end
			reg_cmd_dw1: begin
				prg_rddata = param0_q;
			end
			reg_cmd_dw2: begin
				prg_rddata = param1_q;
			end
			reg_cmd_dw3: begin
				prg_rddata = param2_q;
			end
			default: begin
				prg_rddata = '0;
			end
		endcase
	end

	// To the executor
	assign cmd_pending = type_q != cmd_none;
	assign cmd_type = cmd_t'(type_q);
	assign param0 = param0_q;
	assign param1 = param1_q;
	assign param2 = param2_q;

endmodule

// ==== rtl/cmd_ctl_pkg.sv ====
// Command controller sizes, command codes, register addresses, timing constants, response codes
package cmd_ctl_pkg;

	// ------------------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------------------
	localparam int data_w = 32;
	localparam int addr_w = 8;
	localparam int resp_w = 128;

	// Execute cycle counter, wide enough for the longest command
	localparam int cnt_w = 6;

	// ------------------------------------------------------------------------
	// Command codes written by the host into cmd_dw0
	// ------------------------------------------------------------------------
	typedef enum logic [data_w-1:0] {
		cmd_none = '0,
		cmd_reset,
		cmd_start_sfp1,
		cmd_stop_sfp1,
		cmd_start_sfp2,
		cmd_stop_sfp2,
		cmd_get_rx_size,
		cmd_get_tx_size,
		cmd_get_rx_block_size,
		cmd_set_addr_irq,
		cmd_config_irq,
		cmd_set_rx_block_size,
		cmd_lpbk_on,
		cmd_lpbk_off,
		cmd_init_netlogic
	} cmd_t;

	// ------------------------------------------------------------------------
	// Register addresses
	// ------------------------------------------------------------------------
	// Host command register file
	localparam logic [addr_w-1:0] reg_cmd_dw0 = 8'd0;
	localparam logic [addr_w-1:0] reg_cmd_dw1 = 8'd4;
	localparam logic [addr_w-1:0] reg_cmd_dw2 = 8'd8;
	localparam logic [addr_w-1:0] reg_cmd_dw3 = 8'd12;

	// Interrupt generator register file
	localparam logic [addr_w-1:0] irq_cntl_dw0 = 8'd0;
	localparam logic [addr_w-1:0] irq_cntl_dw1 = 8'd4;
	localparam logic [addr_w-1:0] irq_cntl_dw2 = 8'd8;
	localparam logic [addr_w-1:0] irq_cntl_dw3 = 8'd12;

	// ------------------------------------------------------------------------
	// Command timing and reported sizes
	// ------------------------------------------------------------------------
	localparam logic [data_w-1:0] ring_size = 32'd8192;
	localparam logic [cnt_w-1:0] reset_cycles = 6'd4;
	localparam logic [cnt_w-1:0] lpbk_cycles = 6'd40;
	localparam logic [cnt_w-1:0] nios_pulse_cycles = 6'd5;
	localparam logic [cnt_w-1:0] netlogic_cycles = 6'd40;

	// Response error codes
	localparam logic [data_w-1:0] resp_ok = 32'd0;
	localparam logic [data_w-1:0] resp_unknown = 32'd1;

endpackage
